// ==== all.f ====
+incdir+tb
logic/icache_pkg.sv
logic/icache_ram.sv
logic/icache_lookup.sv
logic/icache_repl.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tb/tb_icache.sv

// ==== logic/icache_ctrl.sv ====
// icache controller
// fsm for flush, lookup and refill, plus enable, pending flush and invalidation state
// drives the per way array strobes and the memory request
module icache_ctrl #(
  parameter int unsigned NumWays = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               en_i,
  input  logic                               flush_i,
  input  logic                               req_i,
  input  icache_pkg::paddr_t                 paddr_i,
  output logic                               ready_o,
  output logic                               valid_o,
  input  logic                               hit_i,
  input  logic                               mem_rtrn_vld_i,
  input  icache_pkg::mem_rtrn_t              mem_rtrn_i,
  input  logic                               mem_ack_i,
  output logic                               mem_req_o,
  output icache_pkg::mem_req_t               mem_req_data_o,
  output logic                               miss_o,
  output logic                               busy_o,
  output logic [NumWays-1:0]                 arr_req_o,
  output logic                               tag_we_o,
  output logic                               data_we_o,
  output icache_pkg::index_t                 arr_addr_o,
  output icache_pkg::tag_entry_t             tag_wdata_o,
  output logic                               cmp_en_o,
  output icache_pkg::tag_t                   tag_o,
  output logic [icache_pkg::OffsetWidth-1:0] offset_o,
  input  logic [NumWays-1:0]                 repl_oh_i,
  output logic                               repl_update_o,
  output logic                               repl_sample_o
);

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} state_e;

  state_e             state_d, state_q;
  logic               cache_en_d, cache_en_q;
  logic               flush_d, flush_q;
  logic               cmp_en_d, cmp_en_q;
  logic               nc_d, nc_q;
  logic               inv_en, inv_q;
  logic               flush_en, flush_done;
  logic               fill_en, rden, accept;
  icache_pkg::index_t flush_cnt_q, lookup_idx;
  icache_pkg::paddr_t paddr_q;

  //////////////////////////////////////////////////////////////////////
  // request fields
  //////////////////////////////////////////////////////////////////////

  assign accept = ready_o && req_i;

  // io region or cache off, decided once per request
  assign nc_d = paddr_i[icache_pkg::NcBit] || !cache_en_q;

  assign tag_o    = paddr_q[icache_pkg::PaddrWidth-1 -: icache_pkg::TagWidth];
  assign offset_o = paddr_q[icache_pkg::OffsetWidth-1:0];
  assign cmp_en_o = cmp_en_q;

  // new index on accept, held index for a retry
  assign lookup_idx = accept ? paddr_i[icache_pkg::OffsetWidth +: icache_pkg::IndexWidth] :
                               paddr_q[icache_pkg::OffsetWidth +: icache_pkg::IndexWidth];

  // word address for nc, line address otherwise
  assign mem_req_data_o.paddr = nc_q ?
      {paddr_q[icache_pkg::PaddrWidth-1:2], 2'b00} :
      {paddr_q[icache_pkg::PaddrWidth-1:icache_pkg::OffsetWidth], {icache_pkg::OffsetWidth{1'b0}}};
  assign mem_req_data_o.nc = nc_q;

  assign inv_en     = mem_rtrn_vld_i && (mem_rtrn_i.rtype == icache_pkg::RTRN_INV);
  assign flush_done = (flush_cnt_q == icache_pkg::index_t'(icache_pkg::NumSets - 1));
  assign busy_o     = (state_q != IDLE);

  //////////////////////////////////////////////////////////////////////
  // fsm
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d       = state_q;
    // dropping the enable is immediate, raising it goes through a flush
    cache_en_d    = cache_en_q && en_i;
    flush_d       = flush_q || flush_i;
    cmp_en_d      = 1'b0;
    flush_en      = 1'b0;
    fill_en       = 1'b0;
    rden          = 1'b0;
    ready_o       = 1'b0;
    valid_o       = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;
    repl_sample_o = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          // a return here is an invalidation, it owns the arrays
          ready_o = !mem_rtrn_vld_i;
        end
      end
      READ: begin
        if (cmp_en_q && inv_q) begin
          // rdata came from the invalidated set, look up again
          rden     = 1'b1;
          cmp_en_d = 1'b1;
        end else if (hit_i) begin
          valid_o = 1'b1;
          state_d = IDLE;
          ready_o = !mem_rtrn_vld_i && !flush_d;
        end else begin
          // compare is off from here on, which keeps the request up
          mem_req_o     = 1'b1;
          repl_sample_o = cmp_en_q;
          if (mem_ack_i) begin
            miss_o  = !nc_q;
            state_d = MISS;
          end
        end
      end
      MISS: begin
        if (mem_rtrn_vld_i && (mem_rtrn_i.rtype == icache_pkg::RTRN_FILL)) begin
          valid_o = 1'b1;
          fill_en = !nc_q;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase

    if (accept) begin
      rden     = 1'b1;
      cmp_en_d = !nc_d;
      state_d  = READ;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // array control
  //////////////////////////////////////////////////////////////////////

  // flush before invalidation before fill before lookup
  assign arr_addr_o = flush_en ? flush_cnt_q :
                      inv_en   ? mem_rtrn_i.inv.idx :
                      fill_en  ? paddr_q[icache_pkg::OffsetWidth +: icache_pkg::IndexWidth] :
                                 lookup_idx;

  always_comb begin : p_way_en
    if (flush_en) begin
      arr_req_o = '1;
    end else if (inv_en && mem_rtrn_i.inv.all) begin
      arr_req_o = '1;
    end else if (inv_en && mem_rtrn_i.inv.vld) begin
      arr_req_o = NumWays'(1) << mem_rtrn_i.inv.way;
    end else if (fill_en) begin
      arr_req_o = repl_oh_i;
    end else if (rden && !inv_en) begin
      arr_req_o = '1;
    end else begin
      arr_req_o = '0;
    end
  end

  assign tag_we_o          = flush_en || inv_en || fill_en;
  assign data_we_o         = fill_en;
  assign tag_wdata_o.valid = fill_en;
  assign tag_wdata_o.tag   = tag_o;
  assign repl_update_o     = fill_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      cmp_en_q    <= 1'b0;
      nc_q        <= 1'b0;
      inv_q       <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      cmp_en_q   <= cmp_en_d;
      inv_q      <= inv_en;
      if (accept) begin
        nc_q <= nc_d;
      end
      if (flush_en) begin
        flush_cnt_q <= flush_done ? '0 : flush_cnt_q + 1'b1;
      end
    end
  end

  // request address
  always_ff @(posedge clk_i) begin : p_paddr
    if (accept) begin
      paddr_q <= paddr_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // set counter only moves while flushing and rewinds at the last set
  a_flush_cnt_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (state_q != FLUSH) |-> (flush_cnt_q == '0))
    else $error("icache_ctrl: flush counter running outside flush");

  // a refill request stays up until memory takes it
  a_req_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (mem_req_o && !mem_ack_i) |=> mem_req_o)
    else $error("icache_ctrl: refill request dropped before ack");

endmodule

// ==== logic/icache_lookup.sv ====
// icache lookup
// tag compare for all ways, first hit encode and fetch word select
// from either the hit line or the line on the return channel
module icache_lookup #(
  parameter int unsigned NumWays = 4
) (
  input  logic                                      cmp_en_i,
  input  icache_pkg::tag_t                          tag_i,
  input  logic [icache_pkg::OffsetWidth-1:0]        offset_i,
  input  icache_pkg::tag_entry_t [NumWays-1:0]      tag_rdata_i,
  input  icache_pkg::line_t      [NumWays-1:0]      line_rdata_i,
  input  icache_pkg::line_t                         fill_line_i,
  output logic                                      hit_o,
  output logic [$clog2(NumWays)-1:0]                hit_way_o,
  output icache_pkg::fetch_t                        data_o
);

  localparam int unsigned WayWidth = $clog2(NumWays);

  logic [NumWays-1:0]                     way_hit;
  logic [icache_pkg::OffsetWidth-3:0]     word_idx;
  icache_pkg::line_t                      sel_line;

  // per way compare against the registered tag
  for (genvar i = 0; i < NumWays; i++) begin : gen_cmp
    assign way_hit[i] = tag_rdata_i[i].valid && (tag_rdata_i[i].tag == tag_i);
  end

  // lowest hitting way wins
  always_comb begin : p_hit_enc
    hit_way_o = '0;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (way_hit[i]) begin
        hit_way_o = WayWidth'(i);
      end
    end
  end

  assign hit_o = cmp_en_i && (|way_hit);

  // compare off means the word comes from the fill line
  // nc returns carry their word at its own offset in the line
  assign sel_line = cmp_en_i ? line_rdata_i[hit_way_o] : fill_line_i;
  assign word_idx = offset_i[icache_pkg::OffsetWidth-1:2];
  assign data_o   = sel_line[word_idx*icache_pkg::FetchWidth +: icache_pkg::FetchWidth];

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // a line is never allocated twice in one set
  always_comb begin : p_hit_chk
    a_hit_onehot: assert final (!cmp_en_i || $onehot0(way_hit))
      else $error("icache_lookup: more than one way hit");
  end

endmodule

// ==== logic/icache_pkg.sv ====
// icache shared definitions
// address split, array entry layouts and the memory-side request and return formats
package icache_pkg;

  //////////////////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned PaddrWidth  = 32;
  localparam int unsigned LineBytes   = 16;
  localparam int unsigned NumSets     = 64;
  localparam int unsigned OffsetWidth = 4;
  localparam int unsigned IndexWidth  = 6;
  localparam int unsigned TagWidth    = 22;
  localparam int unsigned FetchWidth  = 32;
  localparam int unsigned LineWidth   = 128;

  // top address bit selects the uncached io region
  localparam int unsigned NcBit = 31;

  typedef logic [PaddrWidth-1:0] paddr_t;
  typedef logic [TagWidth-1:0]   tag_t;
  typedef logic [IndexWidth-1:0] index_t;
  typedef logic [LineWidth-1:0]  line_t;
  typedef logic [FetchWidth-1:0] fetch_t;

  // one tag array word, valid bit on top
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  //////////////////////////////////////////////////////////////////////
  // memory interface
  //////////////////////////////////////////////////////////////////////

  // fill acks and invalidations share the return channel
  typedef enum logic {
    RTRN_FILL = 1'b0,
    RTRN_INV  = 1'b1
  } rtrn_type_e;

  // way field only covers up to 4 ways
  typedef struct packed {
    index_t     idx;
    logic       all;
    logic       vld;
    logic [1:0] way;
  } inv_req_t;

  typedef struct packed {
    rtrn_type_e rtype;
    line_t      data;
    inv_req_t   inv;
  } mem_rtrn_t;

  // line address for cached misses, word address when nc is set
  typedef struct packed {
    paddr_t paddr;
    logic   nc;
  } mem_req_t;

endpackage

// ==== logic/icache_ram.sv ====
// icache array
// single port register array with a one cycle read, entry type set per instance
module icache_ram #(
  parameter type         entry_t  = logic [31:0],
  parameter int unsigned NumWords = 64
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               we_i,
  input  icache_pkg::index_t addr_i,
  input  entry_t             wdata_i,
  output entry_t             rdata_o
);

  // storage
  entry_t mem_q [NumWords];

  // a write does not update the read port
  always_ff @(posedge clk_i) begin : p_array
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // the controller must never present an x index to an enabled array
  a_addr_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni) req_i |-> !$isunknown(addr_i))
    else $error("icache_ram: unknown address on access");

endmodule

// ==== logic/icache_repl.sv ====
// icache replacement
// lowest invalid way first, pseudo random way from an 8 bit lfsr once the set is full
module icache_repl #(
  parameter int unsigned NumWays = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [NumWays-1:0]         vld_rdata_i,
  input  logic                       update_i,
  input  logic                       sample_i,
  output logic [NumWays-1:0]         repl_oh_o,
  output logic [$clog2(NumWays)-1:0] repl_way_o
);

  localparam int unsigned WayWidth = $clog2(NumWays);

  logic [7:0]          lfsr_q;
  logic                all_valid;
  logic [WayWidth-1:0] inv_way;
  logic [WayWidth-1:0] pick_way;
  logic [NumWays-1:0]  repl_oh_d;

  // first free way, scanning from the top so the lowest one sticks
  always_comb begin : p_free_way
    inv_way = '0;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (!vld_rdata_i[i]) begin
        inv_way = WayWidth'(i);
      end
    end
  end

  assign all_valid = &vld_rdata_i;
  assign pick_way  = all_valid ? lfsr_q[WayWidth-1:0] : inv_way;

  // candidate follows the lookup while sampling, else hold
  assign repl_oh_d = sample_i ? (NumWays'(1) << pick_way) : repl_oh_o;

  // binary of the way the fill will land in
  always_comb begin : p_way_enc
    repl_way_o = '0;
    for (int i = 0; i < NumWays; i++) begin
      if (repl_oh_d[i]) begin
        repl_way_o = WayWidth'(i);
      end
    end
  end

  // taps 8,6,5,4, advanced once per fill
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      lfsr_q    <= 8'hb5;
      repl_oh_o <= '0;
    end else begin
      if (update_i) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      end
      repl_oh_o <= repl_oh_d;
    end
  end

endmodule

// ==== logic/icache_top.sv ====
// set associative instruction cache
// controller, replacement, lookup and per way tag and data arrays
module icache_top #(
  parameter int unsigned NumWays = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         en_i,
  input  logic                         flush_i,
  // fetch side
  input  logic                         req_i,
  input  icache_pkg::paddr_t           paddr_i,
  output logic                         ready_o,
  output logic                         valid_o,
  output icache_pkg::fetch_t           data_o,
  // refill request
  output logic                         mem_req_o,
  output icache_pkg::mem_req_t         mem_req_o_data,
  output logic [$clog2(NumWays)-1:0]   mem_way_o,
  input  logic                         mem_ack_i,
  // fills and invalidations
  input  logic                         mem_rtrn_vld_i,
  input  icache_pkg::mem_rtrn_t        mem_rtrn_i,
  // status
  output logic                         miss_o,
  output logic                         busy_o
);

  logic [NumWays-1:0]                         arr_req;
  logic                                       tag_we;
  logic                                       data_we;
  icache_pkg::index_t                         arr_addr;
  icache_pkg::tag_entry_t                     tag_wdata;
  icache_pkg::tag_entry_t [NumWays-1:0]       tag_rdata;
  icache_pkg::line_t      [NumWays-1:0]       line_rdata;
  logic [NumWays-1:0]                         vld_rdata;
  logic                                       cmp_en;
  icache_pkg::tag_t                           tag;
  logic [icache_pkg::OffsetWidth-1:0]         offset;
  logic                                       hit;
  logic [NumWays-1:0]                         repl_oh;
  logic                                       repl_update;
  logic                                       repl_sample;

  icache_ctrl #(
    .NumWays ( NumWays )
  ) i_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .en_i           ( en_i           ),
    .flush_i        ( flush_i        ),
    .req_i          ( req_i          ),
    .paddr_i        ( paddr_i        ),
    .ready_o        ( ready_o        ),
    .valid_o        ( valid_o        ),
    .hit_i          ( hit            ),
    .mem_rtrn_vld_i ( mem_rtrn_vld_i ),
    .mem_rtrn_i     ( mem_rtrn_i     ),
    .mem_ack_i      ( mem_ack_i      ),
    .mem_req_o      ( mem_req_o      ),
    .mem_req_data_o ( mem_req_o_data ),
    .miss_o         ( miss_o         ),
    .busy_o         ( busy_o         ),
    .arr_req_o      ( arr_req        ),
    .tag_we_o       ( tag_we         ),
    .data_we_o      ( data_we        ),
    .arr_addr_o     ( arr_addr       ),
    .tag_wdata_o    ( tag_wdata      ),
    .cmp_en_o       ( cmp_en         ),
    .tag_o          ( tag            ),
    .offset_o       ( offset         ),
    .repl_oh_i      ( repl_oh        ),
    .repl_update_o  ( repl_update    ),
    .repl_sample_o  ( repl_sample    )
  );

  icache_repl #(
    .NumWays ( NumWays )
  ) i_repl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .vld_rdata_i ( vld_rdata   ),
    .update_i    ( repl_update ),
    .sample_i    ( repl_sample ),
    .repl_oh_o   ( repl_oh     ),
    .repl_way_o  ( mem_way_o   )
  );

  // hit way is only needed inside the lookup
  icache_lookup #(
    .NumWays ( NumWays )
  ) i_lookup (
    .cmp_en_i     ( cmp_en          ),
    .tag_i        ( tag             ),
    .offset_i     ( offset          ),
    .tag_rdata_i  ( tag_rdata       ),
    .line_rdata_i ( line_rdata      ),
    .fill_line_i  ( mem_rtrn_i.data ),
    .hit_o        ( hit             ),
    .hit_way_o    (                 ),
    .data_o       ( data_o          )
  );

  //////////////////////////////////////////////////////////////////////
  // per way arrays
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumWays; i++) begin : gen_way
    assign vld_rdata[i] = tag_rdata[i].valid;

    icache_ram #(
      .entry_t  ( icache_pkg::tag_entry_t ),
      .NumWords ( icache_pkg::NumSets     )
    ) i_tag_ram (
      .clk_i   ( clk_i        ),
      .rst_ni  ( rst_ni       ),
      .req_i   ( arr_req[i]   ),
      .we_i    ( tag_we       ),
      .addr_i  ( arr_addr     ),
      .wdata_i ( tag_wdata    ),
      .rdata_o ( tag_rdata[i] )
    );

    // data is written from the return channel
    icache_ram #(
      .entry_t  ( icache_pkg::line_t  ),
      .NumWords ( icache_pkg::NumSets )
    ) i_data_ram (
      .clk_i   ( clk_i           ),
      .rst_ni  ( rst_ni          ),
      .req_i   ( arr_req[i]      ),
      .we_i    ( data_we         ),
      .addr_i  ( arr_addr        ),
      .wdata_i ( mem_rtrn_i.data ),
      .rdata_o ( line_rdata[i]   )
    );
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the icache testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_icache -Mdir obj_dir -o tb_icache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_icache > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

// ==== tb/icache_mem_model.svh ====
// icache reference model
// refill data as a fixed hash of the word address, and the lines resident per set and way
`ifndef ICACHE_MEM_MODEL_SVH
`define ICACHE_MEM_MODEL_SVH

// valid and tag of the line each way holds, as the testbench expects it
icache_pkg::tag_entry_t resident_q [icache_pkg::NumSets][NumWays];

// every bit of the word address feeds the result
function automatic icache_pkg::fetch_t word_hash(input icache_pkg::paddr_t addr);
  logic [31:0] w;
  w = {addr[31:2], 2'b00};
  return (w * 32'h9e3779b1) ^ {w[12:0], w[31:13]} ^ 32'h5a5a1234;
endfunction

// whole line around addr, word 0 in the low bits
function automatic icache_pkg::line_t line_for(input icache_pkg::paddr_t addr);
  icache_pkg::line_t line;
  for (int i = 0; i < 4; i++) begin
    line[i*icache_pkg::FetchWidth +: icache_pkg::FetchWidth] =
        word_hash({addr[31:4], 2'(i), 2'b00});
  end
  return line;
endfunction

function automatic icache_pkg::index_t set_of(input icache_pkg::paddr_t addr);
  return addr[icache_pkg::OffsetWidth +: icache_pkg::IndexWidth];
endfunction

function automatic icache_pkg::tag_t tag_of(input icache_pkg::paddr_t addr);
  return addr[icache_pkg::PaddrWidth-1 -: icache_pkg::TagWidth];
endfunction

function automatic logic is_resident(input icache_pkg::paddr_t addr);
  logic found;
  found = 1'b0;
  for (int w = 0; w < NumWays; w++) begin
    if (resident_q[set_of(addr)][w].valid && (resident_q[set_of(addr)][w].tag == tag_of(addr)))
      found = 1'b1;
  end
  return found;
endfunction

// lowest way with no line in the set of addr, -1 once the set is full
function automatic int free_way(input icache_pkg::paddr_t addr);
  int way;
  way = -1;
  for (int w = NumWays - 1; w >= 0; w--) begin
    if (!resident_q[set_of(addr)][w].valid)
      way = w;
  end
  return way;
endfunction

// flush, disable and re-enable all empty the cache
task automatic forget_all();
  for (int s = 0; s < icache_pkg::NumSets; s++) begin
    for (int w = 0; w < NumWays; w++) begin
      resident_q[s][w] = '0;
    end
  end
endtask

task automatic record_fill(input icache_pkg::paddr_t addr, input logic [WayWidth-1:0] way);
  resident_q[set_of(addr)][way].valid = 1'b1;
  resident_q[set_of(addr)][way].tag   = tag_of(addr);
endtask

task automatic apply_inv(input icache_pkg::inv_req_t inv);
  if (inv.all) begin
    for (int w = 0; w < NumWays; w++) begin
      resident_q[inv.idx][w] = '0;
    end
  end else if (inv.vld) begin
    resident_q[inv.idx][inv.way] = '0;
  end
endtask

`endif

// ==== tb/tb_icache.sv ====
// icache testbench
// random fetches over a small line pool, checked against a model of resident lines,
// with a memory responder, invalidations, flushes and enable toggles
module tb_icache;

  localparam int unsigned NumWays  = 4;
  localparam int unsigned WayWidth = $clog2(NumWays);
  localparam int unsigned PoolSize = 20;
  localparam int unsigned NumFetch = 600;
  localparam int unsigned Timeout  = 200;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  en_i;
  logic                  flush_i;
  logic                  req_i;
  icache_pkg::paddr_t    paddr_i;
  logic                  ready_o;
  logic                  valid_o;
  icache_pkg::fetch_t    data_o;
  logic                  mem_req_o;
  icache_pkg::mem_req_t  mem_req_o_data;
  logic [WayWidth-1:0]   mem_way_o;
  logic                  mem_ack_i;
  logic                  mem_rtrn_vld_i;
  icache_pkg::mem_rtrn_t mem_rtrn_i;
  logic                  miss_o;
  logic                  busy_o;

  icache_pkg::paddr_t    pool_q [PoolSize];
  logic                  en_model;
  logic                  cur_nc = 1'b0;
  int                    outstanding = 0;

  `include "icache_mem_model.svh"

  icache_top #(
    .NumWays ( NumWays )
  ) DUT (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .en_i           ( en_i           ),
    .flush_i        ( flush_i        ),
    .req_i          ( req_i          ),
    .paddr_i        ( paddr_i        ),
    .ready_o        ( ready_o        ),
    .valid_o        ( valid_o        ),
    .data_o         ( data_o         ),
    .mem_req_o      ( mem_req_o      ),
    .mem_req_o_data ( mem_req_o_data ),
    .mem_way_o      ( mem_way_o      ),
    .mem_ack_i      ( mem_ack_i      ),
    .mem_rtrn_vld_i ( mem_rtrn_vld_i ),
    .mem_rtrn_i     ( mem_rtrn_i     ),
    .miss_o         ( miss_o         ),
    .busy_o         ( busy_o         )
  );

  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input icache_pkg::fetch_t got,
                            input icache_pkg::fetch_t exp);
    if (got !== exp)
      stop_on_error($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_req(input string name, input icache_pkg::mem_req_t got,
                           input icache_pkg::mem_req_t exp);
    if (got !== exp)
      stop_on_error($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_way(input string name, input logic [WayWidth-1:0] got,
                           input logic [WayWidth-1:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  // valid_o only for an accepted request, miss_o only on a cacheable ack
  always begin : monitor
    @(negedge clk_i);
    #2;
    if (valid_o) begin
      check_flag("valid_o without a request", valid_o, outstanding != 0);
      outstanding = outstanding - 1;
    end
    if (req_i && ready_o) outstanding = outstanding + 1;
    check_flag("miss_o", miss_o, mem_ack_i && !cur_nc);
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // 20 lines over 4 sets, so some sets hold more lines than ways
  task automatic build_pool();
    for (int unsigned i = 0; i < PoolSize; i++) begin
      pool_q[i] = {1'b0, 21'($urandom()), 2'(i % 4), 4'h5, 4'h0};
    end
  endtask

  // random byte in a pool line, now and then aliased into the io region
  function automatic icache_pkg::paddr_t pick_addr();
    icache_pkg::paddr_t addr;
    int unsigned        k;
    k    = $urandom_range(PoolSize - 1, 0);
    addr = pool_q[k] | icache_pkg::paddr_t'($urandom_range(15, 0));
    if ($urandom_range(7, 0) == 0) addr[icache_pkg::NcBit] = 1'b1;
    return addr;
  endfunction

  task automatic fetch(input icache_pkg::paddr_t addr);
    icache_pkg::mem_req_t  exp_req;
    icache_pkg::mem_rtrn_t fill;
    logic                  hit_exp;
    int unsigned           waited;
    int unsigned           ack_delay;
    int unsigned           rtrn_delay;
    int                    free_slot;
    @(negedge clk_i);
    mem_rtrn_vld_i = 1'b0;
    cur_nc         = addr[icache_pkg::NcBit] || !en_model;
    hit_exp        = !cur_nc && is_resident(addr);
    exp_req.paddr  = cur_nc ? {addr[31:2], 2'b00} : {addr[31:4], 4'h0};
    exp_req.nc     = cur_nc;
    fill           = '0;
    fill.rtype     = icache_pkg::RTRN_FILL;
    fill.data      = line_for(addr);
    ack_delay      = $urandom_range(3, 0);
    rtrn_delay     = $urandom_range(5, 1);
    req_i          = 1'b1;
    paddr_i        = addr;
    waited         = 0;
    #2;
    while (!ready_o) begin
      waited++;
      if (waited > Timeout) stop_on_error("timeout: request not accepted within 200 cycles");
      @(negedge clk_i);
      #2;
    end
    // lookup cycle
    @(negedge clk_i);
    req_i     = 1'b0;
    mem_ack_i = !hit_exp && (ack_delay == 0);
    #2;
    check_flag("valid_o on lookup", valid_o, hit_exp);
    check_flag("mem_req_o on lookup", mem_req_o, !hit_exp);
    if (hit_exp) begin
      check_flag("ready_o on hit", ready_o, 1'b1);
      check_word("data_o on hit", data_o, word_hash(addr));
    end else begin
      check_req("mem_req_o_data", mem_req_o_data, exp_req);
      // memory holds off the ack
      for (int unsigned i = 0; i < ack_delay; i++) begin
        @(negedge clk_i);
        mem_ack_i = (i + 1 == ack_delay);
        #2;
        check_flag("mem_req_o held", mem_req_o, 1'b1);
        check_req("mem_req_o_data held", mem_req_o_data, exp_req);
      end
      for (int unsigned i = 0; i < rtrn_delay; i++) begin
        @(negedge clk_i);
        mem_ack_i      = 1'b0;
        mem_rtrn_vld_i = (i + 1 == rtrn_delay);
        mem_rtrn_i     = fill;
        #2;
        check_flag("valid_o on return", valid_o, mem_rtrn_vld_i);
        check_flag("mem_req_o after ack", mem_req_o, 1'b0);
      end
      check_word("data_o on fill", data_o, word_hash(addr));
      if (!cur_nc) begin
        // a free way is taken first, a full set leaves the choice to the lfsr
        free_slot = free_way(addr);
        if (free_slot >= 0) check_way("mem_way_o", mem_way_o, WayWidth'(free_slot));
        record_fill(addr, mem_way_o);
      end
    end
  endtask

  // at most one side event between fetches
  task automatic idle_gap();
    icache_pkg::mem_rtrn_t rtrn;
    int unsigned           kind;
    int unsigned           k;
    @(negedge clk_i);
    mem_rtrn_vld_i = 1'b0;
    kind           = $urandom_range(31, 0);
    k              = $urandom_range(PoolSize - 1, 0);
    if (kind == 0) begin
      flush_i = 1'b1;
      forget_all();
      @(negedge clk_i);
      flush_i = 1'b0;
    end else if ((kind == 1) || (!en_model && (kind < 6))) begin
      // re-enable flushes, disable stops caching at once
      en_model = !en_model;
      en_i     = en_model;
      forget_all();
    end else if (kind < 10) begin
      rtrn          = '0;
      rtrn.rtype    = icache_pkg::RTRN_INV;
      rtrn.inv.idx  = set_of(pool_q[k]);
      rtrn.inv.all  = ($urandom_range(1, 0) == 1);
      rtrn.inv.vld  = !rtrn.inv.all;
      rtrn.inv.way  = 2'($urandom_range(NumWays - 1, 0));
      mem_rtrn_i     = rtrn;
      mem_rtrn_vld_i = 1'b1;
      apply_inv(rtrn.inv);
      #2;
      check_flag("ready_o during invalidation", ready_o, 1'b0);
    end
  endtask

  initial begin : stimulus
    void'($urandom(32'hdb345717));
    rst_ni         = 1'b1;
    en_i           = 1'b1;
    flush_i        = 1'b0;
    req_i          = 1'b0;
    paddr_i        = '0;
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_i     = '0;
    en_model       = 1'b1;
    forget_all();
    build_pool();
    #1 rst_ni = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    // flush clears one set per cycle after reset
    for (int unsigned i = 0; i < icache_pkg::NumSets; i++) begin
      #2;
      check_flag("busy_o during flush", busy_o, 1'b1);
      check_flag("ready_o during flush", ready_o, 1'b0);
      @(negedge clk_i);
    end
    #2;
    check_flag("busy_o after flush", busy_o, 1'b0);
    check_flag("ready_o after flush", ready_o, 1'b1);
    for (int unsigned n = 0; n < NumFetch; n++) begin
      fetch(pick_addr());
      idle_gap();
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule
